// ==== matx.f ====
+incdir+.
matx_pkg.sv
matx_ctrl.sv
tag_scanner.sv
hex_loader.sv
matrix_mac.sv
result_printer.sv
matx_top.sv
tb_matx.sv

// ==== Makefile ====
# Verilator simulation of the matx testbench

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_matx -f matx.f -o sim_matx
	./obj_dir/sim_matx

clean:
	rm -rf obj_dir

// ==== tb_matx.sv ====
`timescale 1ns/1ps

module tb_matx
  import matx_pkg::*;
();

  localparam int FRAMES         = 6;
  localparam int TIMEOUT_CYCLES = FRAMES * 600;
  localparam int FRAME_CHARS    = 128;

  logic         clk;
  logic         reset_n;
  stream_byte_t byte_in;
  stream_byte_t char_out;
  logic         busy;

  int         seed = 42685;
  int         cycle_cnt = 0;
  int         frame_chars = 0;
  int         frames_done = 0;
  logic       prev_valid = 1'b0;
  logic [7:0] exp_q[$];
  logic [7:0] exp_c;
  matrix_t    a;
  matrix_t    b;

  matx_top u_matx_top (
    .clk      (clk),
    .reset_n  (reset_n),
    .byte_in  (byte_in),
    .char_out (char_out),
    .busy     (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // --------------------------------------------------
  // Failure reporting and compares
  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_char(input stream_byte_t got, input stream_byte_t exp);
    if (got !== exp) begin
      $display("Mismatch char_out: got 0x%h expected 0x%h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch char_count: got 0x%h expected 0x%h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch busy: got 0x%h expected 0x%h", got, exp);
      fail_run();
    end
  endtask

  // --------------------------------------------------
  // Reference model of the printed result
  function automatic logic [7:0] to_hex_digit(input logic [3:0] n);
    if (n < 4'd10)
      return 8'h30 + 8'(n);
    return 8'h41 + 8'(n) - 8'd10;
  endfunction

  task automatic push_value(input result_t v);
    exp_q.push_back(8'h30 + 8'(v[17:16]));
    for (int s = 3; s >= 0; s--)
      exp_q.push_back(to_hex_digit(v[4*s +: 4]));
  endtask

  task automatic expect_frame(input matrix_t ma, input matrix_t mb);
    logic [31:0] sum;
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back("[");
      exp_q.push_back(" ");
      for (int j = 0; j < 4; j++) begin
        sum = 32'd0;
        for (int k = 0; k < 4; k++)
          sum = sum + 32'(ma[i*4+k]) * 32'(mb[k*4+j]);
        push_value(sum[17:0]);
        if (j < 3) begin
          exp_q.push_back(",");
          exp_q.push_back(" ");
        end
      end
      exp_q.push_back(" ");
      exp_q.push_back("]");
      exp_q.push_back(8'h0D);
      exp_q.push_back(8'h0A);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  task automatic send_byte(input logic [7:0] data, input int gap);
    @(posedge clk);
    byte_in <= {1'b1, data};
    repeat (gap) begin
      @(posedge clk);
      byte_in <= '0;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      byte_in <= '0;
    end
  endtask

  function automatic int rand_gap();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  task automatic send_text(input string s);
    for (int i = 0; i < s.len(); i++)
      send_byte(s[i], rand_gap());
  endtask

  task automatic send_noise(input int n);
    repeat (n) send_byte(8'($random(seed)), rand_gap());
  endtask

  task automatic fill_random(output matrix_t m);
    for (int idx = 0; idx < 16; idx++)
      m[idx] = 8'($random(seed));
  endtask

  // Line breaks may come before any hex character
  task automatic send_hex_char(input logic [3:0] n, input bit line_breaks);
    int pick;
    pick = int'($unsigned($random(seed)) % 8);
    if (line_breaks && (pick == 0 || pick == 1))
      send_byte(8'h0D, rand_gap());
    if (line_breaks && (pick == 1 || pick == 2))
      send_byte(8'h0A, rand_gap());
    send_byte(to_hex_digit(n), rand_gap());
  endtask

  // Random bytes go in only while the DUT is busy
  task automatic wait_output(input bit busy_noise);
    while (exp_q.size() != 0) begin
      @(posedge clk);
      if (busy_noise && busy && exp_q.size() != 0)
        byte_in <= {1'b1, 8'($random(seed))};
      else
        byte_in <= '0;
    end
    idle(1);
  endtask

  task automatic run_frame(input matrix_t ma, input matrix_t mb,
                           input bit line_breaks, input bit busy_noise);
    element_t e;
    expect_frame(ma, mb);
    @(negedge clk);
    check_busy(busy, 1'b0);
    send_text("MATX_TAG");
    // The byte right after the tag is dropped by the DUT
    idle(2);
    for (int idx = 0; idx < 32; idx++) begin
      e = (idx < 16) ? ma[idx] : mb[idx-16];
      send_hex_char(e[7:4], line_breaks);
      send_hex_char(e[3:0], line_breaks);
    end
    idle(1);
    wait_output(busy_noise);
  endtask

  // --------------------------------------------------
  // Output monitor, sampled away from the driving edge
  always @(negedge clk) begin
    if (reset_n) begin
      if (char_out.valid) begin
        check_busy(busy, 1'b1);
        if (exp_q.size() == 0) begin
          $display("Character 0x%h appeared on char_out with none expected", char_out.data);
          fail_run();
        end
        exp_c = exp_q.pop_front();
        check_char(char_out, {1'b1, exp_c});
        frame_chars++;
      end else if (prev_valid) begin
        check_count(frame_chars, FRAME_CHARS);
        frame_chars = 0;
        frames_done++;
      end
      prev_valid = char_out.valid;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_run();
    end
  end

  initial begin
    reset_n = 1'b0;
    byte_in = '0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    idle(2);

    // Identity times random B
    for (int idx = 0; idx < 16; idx++)
      a[idx] = (idx / 4 == idx % 4) ? 8'd1 : 8'd0;
    fill_random(b);
    run_frame(a, b, 1'b0, 1'b0);

    // Random matrices with scattered CR and LF
    fill_random(a);
    fill_random(b);
    run_frame(a, b, 1'b1, 1'b0);

    // Partial tags and a doubled M ahead of the real tag
    send_noise(12);
    send_text("MATX_TAX");
    send_noise(5);
    send_text("M");
    fill_random(a);
    fill_random(b);
    run_frame(a, b, 1'b0, 1'b0);

    // Largest possible sums
    a = '1;
    b = '1;
    run_frame(a, b, 1'b1, 1'b0);

    // Back to back frames with traffic while busy
    fill_random(a);
    fill_random(b);
    run_frame(a, b, 1'b1, 1'b1);
    fill_random(a);
    fill_random(b);
    run_frame(a, b, 1'b1, 1'b1);

    idle(4);
    if (exp_q.size() != 0 || frames_done != FRAMES) begin
      $display("Run ended with %0d characters outstanding after %0d of %0d frames",
               exp_q.size(), frames_done, FRAMES);
      fail_run();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== matx_top.sv ====
`timescale 1ns/1ps

module matx_top
  import matx_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  stream_byte_t byte_in,
  output stream_byte_t char_out,
  output logic         busy
);

  logic           scan_en;
  logic           load_en;
  logic           mac_start;
  logic           print_start;
  logic           tag_found;
  logic           load_done;
  logic           mac_done;
  logic           print_done;
  matrix_t        a_mat;
  matrix_t        b_mat;
  result_matrix_t result;

  matx_ctrl u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .tag_found   (tag_found),
    .load_done   (load_done),
    .mac_done    (mac_done),
    .print_done  (print_done),
    .scan_en     (scan_en),
    .load_en     (load_en),
    .mac_start   (mac_start),
    .print_start (print_start),
    .busy        (busy)
  );

  tag_scanner u_tag_scanner (
    .clk       (clk),
    .reset_n   (reset_n),
    .scan_en   (scan_en),
    .byte_in   (byte_in),
    .tag_found (tag_found)
  );

  hex_loader u_hex_loader (
    .clk       (clk),
    .reset_n   (reset_n),
    .load_en   (load_en),
    .byte_in   (byte_in),
    .load_done (load_done),
    .a_mat     (a_mat),
    .b_mat     (b_mat)
  );

  matrix_mac u_matrix_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .mac_start (mac_start),
    .a_mat     (a_mat),
    .b_mat     (b_mat),
    .mac_done  (mac_done),
    .result    (result)
  );

  result_printer u_result_printer (
    .clk         (clk),
    .reset_n     (reset_n),
    .print_start (print_start),
    .result      (result),
    .char_out    (char_out),
    .print_done  (print_done)
  );

endmodule

// ==== result_printer.sv ====
`timescale 1ns/1ps
`include "matx_config.svh"

module result_printer
  import matx_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           print_start,
  input  result_matrix_t result,
  output stream_byte_t   char_out,
  output logic           print_done
);

  logic       active;
  logic       last_char;
  logic [6:0] char_idx;
  logic [1:0] row;
  logic [4:0] pos;
  logic [4:0] offs;
  logic [1:0] col;
  logic [2:0] dig;
  result_t    value;
  logic [3:0] nib;
  logic [7:0] ch;

  assign row = char_idx[6:5];
  assign pos = char_idx[4:0];

  // Values start at position 2 and repeat every 7 positions
  assign offs  = pos - 5'd2;
  assign col   = 2'(offs / 5'd7);
  assign dig   = 3'(offs % 5'd7);
  assign value = result[{row, col}];

  always_comb begin
    case (dig)
      3'd1:    nib = value[15:12];
      3'd2:    nib = value[11:8];
      3'd3:    nib = value[7:4];
      default: nib = value[3:0];
    endcase
  end

  // --------------------------------------------------
  // Row template: "[ v, v, v, v ]" CR LF
  always_comb begin
    case (pos)
      5'd0:                             ch = "[";
      5'd1, 5'd8, 5'd15, 5'd22, 5'd28:  ch = " ";
      5'd7, 5'd14, 5'd21:               ch = ",";
      5'd29:                            ch = "]";
      5'(`MATX_ROW_CHARS-2):            ch = 8'h0D;
      5'(`MATX_ROW_CHARS-1):            ch = 8'h0A;
      default: begin
        // Leading digit carries only the top two bits
        if (dig == 3'd0)
          ch = 8'h30 + {6'b0, value[17:16]};
        else if (nib > 4'd9)
          ch = 8'h37 + {4'b0, nib};
        else
          ch = 8'h30 + {4'b0, nib};
      end
    endcase
  end

  // --------------------------------------------------
  // Character sequencing
  assign last_char = (char_idx == 7'(`MATX_OUT_CHARS-1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      active   <= 1'b0;
      char_idx <= 7'd0;
    end else if (print_start) begin
      active   <= 1'b1;
      char_idx <= 7'd0;
    end else if (active) begin
      char_idx <= char_idx + 7'd1;
      if (last_char) active <= 1'b0;
    end
  end

  assign char_out.valid = active;
  assign char_out.data  = ch;
  assign print_done     = active && last_char;

  // One unbroken burst per start, then silence
  a_burst: assert property (@(posedge clk) disable iff (!reset_n)
    print_start |=> char_out.valid [*`MATX_OUT_CHARS] ##1 !char_out.valid);

endmodule

// ==== matrix_mac.sv ====
`timescale 1ns/1ps
`include "matx_config.svh"

module matrix_mac
  import matx_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           mac_start,
  input  matrix_t        a_mat,
  input  matrix_t        b_mat,
  output logic           mac_done,
  output result_matrix_t result
);

  logic        active;
  logic        do_step;
  logic [3:0]  step;
  logic [1:0]  term;
  logic [1:0]  row;
  logic [15:0] prod [`MATX_DIM];

  assign do_step = mac_start | active;
  assign term    = step[3:2];
  assign row     = step[1:0];

  // Step 0 runs in the start cycle, step 15 raises done
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      active   <= 1'b0;
      step     <= 4'd0;
      mac_done <= 1'b0;
    end else begin
      mac_done <= do_step && (step == 4'hf);
      if (do_step) begin
        step   <= step + 4'd1;
        active <= (step != 4'hf);
      end
    end
  end

  // A[row][term] times one row of B
  always_comb begin
    for (int j = 0; j < `MATX_DIM; j++) begin
      prod[j] = a_mat[{row, term}] * b_mat[{term, 2'(j)}];
    end
  end

  always_ff @(posedge clk) begin
    if (do_step) begin
      for (int j = 0; j < `MATX_DIM; j++) begin
        if (term == 2'd0)
          result[{row, 2'(j)}] <= {2'b00, prod[j]};
        else
          result[{row, 2'(j)}] <= result[{row, 2'(j)}] + {2'b00, prod[j]};
      end
    end
  end

endmodule

// ==== hex_loader.sv ====
`timescale 1ns/1ps
`include "matx_config.svh"

module hex_loader
  import matx_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         load_en,
  input  stream_byte_t byte_in,
  output logic         load_done,
  output matrix_t      a_mat,
  output matrix_t      b_mat
);

  logic [5:0] char_cnt;
  logic       full;
  logic       is_line_end;
  logic       last_char;
  logic       accept;
  logic [3:0] nibble;
  logic [3:0] high_nib;

  assign is_line_end = (byte_in.data == 8'h0D) || (byte_in.data == 8'h0A);
  assign last_char   = (char_cnt == 6'(`MATX_HEX_CHARS-1));
  assign accept      = load_en && byte_in.valid && !is_line_end && !full;

  // Letters have bit 6 set, so 'A' is 1 + 9
  assign nibble = byte_in.data[6] ? byte_in.data[3:0] + 4'd9 : byte_in.data[3:0];

  // --------------------------------------------------
  // Character count
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      char_cnt  <= 6'd0;
      full      <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load_done <= accept && last_char;
      if (!load_en) begin
        char_cnt <= 6'd0;
        full     <= 1'b0;
      end else if (accept) begin
        char_cnt <= char_cnt + 6'd1;
        if (last_char) full <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Even characters hold the high nibble, odd ones complete an element
  always_ff @(posedge clk) begin
    if (accept) begin
      if (!char_cnt[0])
        high_nib <= nibble;
      else if (!char_cnt[5])
        a_mat[char_cnt[4:1]] <= {high_nib, nibble};
      else
        b_mat[char_cnt[4:1]] <= {high_nib, nibble};
    end
  end

  // Matrices stay frozen once the frame is complete
  a_frozen_when_full: assert property (@(posedge clk) disable iff (!reset_n)
    full |=> $stable(a_mat) && $stable(b_mat));

endmodule

// ==== tag_scanner.sv ====
`timescale 1ns/1ps
`include "matx_config.svh"

module tag_scanner
  import matx_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         scan_en,
  input  stream_byte_t byte_in,
  output logic         tag_found
);

  localparam logic [8*`MATX_TAG_LEN-1:0] TAG_TEXT = `MATX_TAG_TEXT;

  logic [2:0] match_idx;
  logic [7:0] expect_char;
  logic [7:0] first_char;

  // First letter of the text is in the top byte
  assign expect_char = TAG_TEXT[8*(`MATX_TAG_LEN-1-match_idx) +: 8];
  assign first_char  = TAG_TEXT[8*(`MATX_TAG_LEN-1) +: 8];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      match_idx <= 3'd0;
      tag_found <= 1'b0;
    end else begin
      tag_found <= 1'b0;
      if (!scan_en) begin
        match_idx <= 3'd0;
      end else if (byte_in.valid) begin
        if (byte_in.data == expect_char) begin
          if (match_idx == 3'(`MATX_TAG_LEN-1)) begin
            tag_found <= 1'b1;
            match_idx <= 3'd0;
          end else begin
            match_idx <= match_idx + 3'd1;
          end
        end else if (byte_in.data == first_char) begin
          // A broken match may already be the start of the next one
          match_idx <= 3'd1;
        end else begin
          match_idx <= 3'd0;
        end
      end
    end
  end

endmodule

// ==== matx_ctrl.sv ====
`timescale 1ns/1ps

module matx_ctrl
  import matx_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic tag_found,
  input  logic load_done,
  input  logic mac_done,
  input  logic print_done,
  output logic scan_en,
  output logic load_en,
  output logic mac_start,
  output logic print_start,
  output logic busy
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  // --------------------------------------------------
  // Frame sequencing
  always_comb begin
    state_next = state;
    case (state)
      S_SCAN:
        if (tag_found) state_next = S_LOAD;
      S_LOAD:
        if (load_done) state_next = S_MULT;
      S_MULT:
        if (mac_done) state_next = S_EMIT;
      S_EMIT:
        if (print_done) state_next = S_SCAN;
      default:
        state_next = S_SCAN;
    endcase
  end

  // Start pulses line up with the first cycle of their state
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state       <= S_SCAN;
      mac_start   <= 1'b0;
      print_start <= 1'b0;
    end else begin
      state       <= state_next;
      mac_start   <= (state == S_LOAD) && (state_next == S_MULT);
      print_start <= (state == S_MULT) && (state_next == S_EMIT);
    end
  end

  assign scan_en = (state == S_SCAN);
  assign load_en = (state == S_LOAD);
  assign busy    = (state == S_MULT) || (state == S_EMIT);

  a_start_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(mac_start && print_start));

  // The multiplier answers in a fixed number of cycles
  a_mac_latency: assert property (@(posedge clk) disable iff (!reset_n)
    mac_start |-> ##16 mac_done);

endmodule

// ==== matx_pkg.sv ====
`include "matx_config.svh"

package matx_pkg;

  // One byte on a single-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } stream_byte_t;

  typedef logic [7:0] element_t;

  // Row-major, element r*DIM+c sits at index r*DIM+c
  typedef element_t [`MATX_DIM*`MATX_DIM-1:0] matrix_t;

  typedef logic [`MATX_RESULT_W-1:0] result_t;

  typedef result_t [`MATX_DIM*`MATX_DIM-1:0] result_matrix_t;

  typedef enum logic [1:0] {
    S_SCAN,
    S_LOAD,
    S_MULT,
    S_EMIT
  } ctrl_state_e;

endpackage

// ==== matx_config.svh ====
`ifndef MATX_CONFIG_SVH
`define MATX_CONFIG_SVH

// Frame geometry
`define MATX_DIM        4
`define MATX_HEX_CHARS  64
`define MATX_RESULT_W   18

// Printed result layout
`define MATX_ROW_CHARS  32
`define MATX_OUT_CHARS  128

// Start-of-frame marker in the byte stream
`define MATX_TAG_TEXT   "MATX_TAG"
`define MATX_TAG_LEN    8

`endif
